// ==== verilog/deep_fifo_pkg.sv ====
package deep_fifo_pkg;

	////////////////////////////////////////////////////////////
	// Data widths
	////////////////////////////////////////////////////////////

	localparam int WORD_W          = 16;
	localparam int WORDS_PER_CHUNK = 4;
	localparam int CHUNK_W         = WORD_W * WORDS_PER_CHUNK;
	localparam int COUNT_W         = 32;

	// Capacities in chunks
	localparam int PACK_DEPTH   = 16;
	localparam int UNPACK_DEPTH = 16;
	localparam int STORE_DEPTH  = 256;

	// Derived sizes for pointer slicing
	localparam int LANE_W       = $clog2(WORDS_PER_CHUNK);
	localparam int PACK_ROW_W   = $clog2(PACK_DEPTH);
	localparam int UNPACK_ROW_W = $clog2(UNPACK_DEPTH);
	localparam int PACK_WORDS   = PACK_DEPTH * WORDS_PER_CHUNK;
	localparam int STORE_AW     = $clog2(STORE_DEPTH);

	////////////////////////////////////////////////////////////
	// Types
	////////////////////////////////////////////////////////////

	typedef logic [WORD_W-1:0]           word_t;
	typedef logic [CHUNK_W-1:0]          chunk_t;
	typedef logic [STORE_AW-1:0]         store_addr_t;
	typedef logic [STORE_AW:0]           chunk_level_t;
	typedef logic [$clog2(PACK_WORDS):0] word_level_t;
	typedef logic [COUNT_W-1:0]          count_t;

	// Unpacker must keep one slot spare for a chunk still in flight
	localparam chunk_level_t READ_FREE_MIN = chunk_level_t'(2);

	typedef enum logic [1:0] {
		IDLE,
		MOVE_IN,
		READ_REQ,
		READ_LAND
	} xfer_state_t;

endpackage

// ==== verilog/chunk_if.sv ====
`timescale 1ns/1ps

// Head of the input buffer, seen by the transfer controller
interface pack_port_if;
	logic                       pop;
	deep_fifo_pkg::chunk_t      chunk;
	logic                       chunk_ready;
	deep_fifo_pkg::word_level_t word_level;

	modport packer (input pop, output chunk, output chunk_ready, output word_level);
	modport ctrl (output pop, input chunk, input chunk_ready);
endinterface

// Store write and read side, plus the landing of chunks in the unpacker
interface store_port_if;
	logic                        wr_en;
	deep_fifo_pkg::chunk_t       wr_chunk;
	logic                        rd_en;
	logic                        push;
	deep_fifo_pkg::chunk_t       rd_chunk;
	deep_fifo_pkg::chunk_level_t chunk_level;
	deep_fifo_pkg::chunk_level_t free_chunks;
	deep_fifo_pkg::word_level_t  word_level;

	modport ctrl (
		output wr_en, output wr_chunk, output rd_en, output push,
		input chunk_level, input free_chunks
	);
	modport store (
		input wr_en, input wr_chunk, input rd_en,
		output rd_chunk, output chunk_level
	);
	modport unpacker (input push, output free_chunks, output word_level);
endinterface

// ==== verilog/word_packer.sv ====
`timescale 1ns/1ps

module word_packer (
	input  logic                 ti_clk,
	input  logic                 rst_n,
	input  logic                 fifo_write,
	input  deep_fifo_pkg::word_t fifo_data_in,
	pack_port_if.packer          port
);

	// Each row holds one chunk, lane 0 in the low bits
	deep_fifo_pkg::word_t [deep_fifo_pkg::WORDS_PER_CHUNK-1:0] mem [deep_fifo_pkg::PACK_DEPTH];

	// Word pointers with one extra wrap bit
	deep_fifo_pkg::word_level_t wr_ptr;
	deep_fifo_pkg::word_level_t rd_ptr;
	deep_fifo_pkg::word_level_t level;

	logic [deep_fifo_pkg::LANE_W-1:0]     wr_lane;
	logic [deep_fifo_pkg::PACK_ROW_W-1:0] wr_row;
	logic [deep_fifo_pkg::PACK_ROW_W-1:0] rd_row;
	logic                                 accept;

	assign level   = wr_ptr - rd_ptr;
	assign wr_lane = wr_ptr[deep_fifo_pkg::LANE_W-1:0];
	assign wr_row  = wr_ptr[deep_fifo_pkg::LANE_W +: deep_fifo_pkg::PACK_ROW_W];
	assign rd_row  = rd_ptr[deep_fifo_pkg::LANE_W +: deep_fifo_pkg::PACK_ROW_W];

	// A word that arrives while full is lost
	assign accept = fifo_write &&
		(level != deep_fifo_pkg::word_level_t'(deep_fifo_pkg::PACK_WORDS));

	////////////////////////////////////////////////////////////
	// Pointers
	////////////////////////////////////////////////////////////

	always_ff @(posedge ti_clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (accept) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			// Pop always takes a whole chunk
			if (port.pop) begin
				rd_ptr <= rd_ptr +
					deep_fifo_pkg::word_level_t'(deep_fifo_pkg::WORDS_PER_CHUNK);
			end
		end
	end

	always_ff @(posedge ti_clk) begin
		if (accept) begin
			mem[wr_row][wr_lane] <= fifo_data_in;
		end
	end

	////////////////////////////////////////////////////////////
	// Head chunk, shown ahead of the pop
	////////////////////////////////////////////////////////////

	assign port.chunk       = mem[rd_row];
	assign port.chunk_ready = level >=
		deep_fifo_pkg::word_level_t'(deep_fifo_pkg::WORDS_PER_CHUNK);

	// Residual words of a partial chunk are counted as well
	assign port.word_level = level;

	// Controller may only pop a complete chunk
	pop_needs_chunk: assert property (
		@(posedge ti_clk) disable iff (!rst_n)
		port.pop |-> port.chunk_ready
	);

endmodule

// ==== verilog/word_unpacker.sv ====
`timescale 1ns/1ps

module word_unpacker (
	input  logic                  ti_clk,
	input  logic                  rst_n,
	store_port_if.unpacker        port,
	input  deep_fifo_pkg::chunk_t rd_chunk,
	input  logic                  fifo_read,
	output deep_fifo_pkg::word_t  fifo_data_out
);

	deep_fifo_pkg::word_t [deep_fifo_pkg::WORDS_PER_CHUNK-1:0] mem [deep_fifo_pkg::UNPACK_DEPTH];

	// Word pointers; the write side only moves by whole chunks
	deep_fifo_pkg::word_level_t wr_ptr;
	deep_fifo_pkg::word_level_t rd_ptr;
	deep_fifo_pkg::word_level_t level;

	logic [deep_fifo_pkg::UNPACK_ROW_W-1:0] wr_row;
	logic [deep_fifo_pkg::UNPACK_ROW_W-1:0] rd_row;
	logic [deep_fifo_pkg::LANE_W-1:0]       rd_lane;
	logic [deep_fifo_pkg::UNPACK_ROW_W:0]   used_rows;
	logic                                   empty;

	assign level   = wr_ptr - rd_ptr;
	assign empty   = (level == '0);
	assign wr_row  = wr_ptr[deep_fifo_pkg::LANE_W +: deep_fifo_pkg::UNPACK_ROW_W];
	assign rd_row  = rd_ptr[deep_fifo_pkg::LANE_W +: deep_fifo_pkg::UNPACK_ROW_W];
	assign rd_lane = rd_ptr[deep_fifo_pkg::LANE_W-1:0];

	// A partly read row still holds its slot
	assign used_rows = wr_ptr[deep_fifo_pkg::LANE_W +: deep_fifo_pkg::UNPACK_ROW_W + 1] -
		rd_ptr[deep_fifo_pkg::LANE_W +: deep_fifo_pkg::UNPACK_ROW_W + 1];

	assign port.free_chunks = deep_fifo_pkg::chunk_level_t'(deep_fifo_pkg::UNPACK_DEPTH) -
		deep_fifo_pkg::chunk_level_t'(used_rows);
	assign port.word_level  = level;

	////////////////////////////////////////////////////////////
	// Pointers and output word
	////////////////////////////////////////////////////////////

	always_ff @(posedge ti_clk) begin
		if (!rst_n) begin
			wr_ptr        <= '0;
			rd_ptr        <= '0;
			fifo_data_out <= '0;
		end else begin
			if (port.push) begin
				wr_ptr <= wr_ptr +
					deep_fifo_pkg::word_level_t'(deep_fifo_pkg::WORDS_PER_CHUNK);
			end
			// Empty read keeps the last word on the output
			if (fifo_read && !empty) begin
				fifo_data_out <= mem[rd_row][rd_lane];
				rd_ptr        <= rd_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge ti_clk) begin
		if (port.push) begin
			mem[wr_row] <= rd_chunk;
		end
	end

	// Landing chunk must find a free row
	push_needs_room: assert property (
		@(posedge ti_clk) disable iff (!rst_n)
		port.push |-> (port.free_chunks != '0)
	);

endmodule

// ==== verilog/bulk_store.sv ====
`timescale 1ns/1ps

module bulk_store (
	input  logic        ti_clk,
	input  logic        rst_n,
	store_port_if.store port
);

	deep_fifo_pkg::chunk_t mem [deep_fifo_pkg::STORE_DEPTH];

	// Chunk pointers, one bit wider than the address
	deep_fifo_pkg::chunk_level_t wr_ptr;
	deep_fifo_pkg::chunk_level_t rd_ptr;

	deep_fifo_pkg::store_addr_t wr_addr;
	deep_fifo_pkg::store_addr_t rd_addr;

	assign wr_addr = deep_fifo_pkg::store_addr_t'(wr_ptr);
	assign rd_addr = deep_fifo_pkg::store_addr_t'(rd_ptr);

	////////////////////////////////////////////////////////////
	// Circular pointers
	////////////////////////////////////////////////////////////

	// Writer laps unread data when the store is full
	always_ff @(posedge ti_clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (port.wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (port.rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Memory with registered read
	////////////////////////////////////////////////////////////

	always_ff @(posedge ti_clk) begin
		if (port.wr_en) begin
			mem[wr_addr] <= port.wr_chunk;
		end
		// Data appears the cycle after rd_en
		if (port.rd_en) begin
			port.rd_chunk <= mem[rd_addr];
		end
	end

	assign port.chunk_level = wr_ptr - rd_ptr;

endmodule

// ==== verilog/transfer_ctrl.sv ====
`timescale 1ns/1ps

module transfer_ctrl (
	input  logic       ti_clk,
	input  logic       rst_n,
	pack_port_if.ctrl  pack,
	store_port_if.ctrl store
);

	deep_fifo_pkg::xfer_state_t state;
	deep_fifo_pkg::xfer_state_t state_nxt;

	logic can_read;

	// Store has data and the unpacker has room for this chunk plus one in flight
	assign can_read = (store.chunk_level != '0) &&
		(store.free_chunks >= deep_fifo_pkg::READ_FREE_MIN);

	////////////////////////////////////////////////////////////
	// State register
	////////////////////////////////////////////////////////////

	always_ff @(posedge ti_clk) begin
		if (!rst_n) begin
			state <= deep_fifo_pkg::IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	////////////////////////////////////////////////////////////
	// Next state
	////////////////////////////////////////////////////////////

	always_comb begin
		state_nxt = state;
		case (state)
			// Arbitrate; writes win so the input buffer never backs up
			deep_fifo_pkg::IDLE,
			deep_fifo_pkg::READ_LAND: begin
				if (pack.chunk_ready) begin
					state_nxt = deep_fifo_pkg::MOVE_IN;
				end else if (can_read) begin
					state_nxt = deep_fifo_pkg::READ_REQ;
				end else begin
					state_nxt = deep_fifo_pkg::IDLE;
				end
			end

			// Head chunk goes straight into the store
			deep_fifo_pkg::MOVE_IN: begin
				state_nxt = deep_fifo_pkg::IDLE;
			end

			// Store data returns next cycle
			deep_fifo_pkg::READ_REQ: begin
				state_nxt = deep_fifo_pkg::READ_LAND;
			end

			default: begin
				state_nxt = deep_fifo_pkg::IDLE;
			end
		endcase
	end

	////////////////////////////////////////////////////////////
	// Strobes decoded from state
	////////////////////////////////////////////////////////////

	assign pack.pop       = (state == deep_fifo_pkg::MOVE_IN);
	assign store.wr_en    = (state == deep_fifo_pkg::MOVE_IN);
	assign store.wr_chunk = pack.chunk;
	assign store.rd_en    = (state == deep_fifo_pkg::READ_REQ);

	// rd_chunk is valid in this state, so the unpacker takes it now
	assign store.push = (state == deep_fifo_pkg::READ_LAND);

endmodule

// ==== verilog/occupancy_monitor.sv ====
`timescale 1ns/1ps

module occupancy_monitor (
	input  logic                        ti_clk,
	input  logic                        rst_n,
	input  deep_fifo_pkg::word_level_t  pack_level,
	input  deep_fifo_pkg::chunk_level_t store_level,
	input  deep_fifo_pkg::word_level_t  unpack_level,
	output deep_fifo_pkg::count_t       num_words
);

	deep_fifo_pkg::count_t store_words;
	deep_fifo_pkg::count_t total;

	// Store level is kept in chunks
	assign store_words = deep_fifo_pkg::count_t'(store_level) *
		deep_fifo_pkg::count_t'(deep_fifo_pkg::WORDS_PER_CHUNK);

	assign total = deep_fifo_pkg::count_t'(pack_level) +
		store_words +
		deep_fifo_pkg::count_t'(unpack_level);

	// One cycle behind the levels it sums
	always_ff @(posedge ti_clk) begin
		if (!rst_n) begin
			num_words <= '0;
		end else begin
			num_words <= total;
		end
	end

endmodule

// ==== verilog/deep_fifo_top.sv ====
`timescale 1ns/1ps

module deep_fifo_top (
	input  logic                  ti_clk,
	input  logic                  rst_n,
	input  logic                  fifo_write,
	input  deep_fifo_pkg::word_t  fifo_data_in,
	input  logic                  fifo_read,
	output deep_fifo_pkg::word_t  fifo_data_out,
	output deep_fifo_pkg::count_t num_words
);

	pack_port_if  u_pack_if ();
	store_port_if u_store_if ();

	////////////////////////////////////////////////////////////
	// Datapath
	////////////////////////////////////////////////////////////

	word_packer u_word_packer (
		.ti_clk       (ti_clk),
		.rst_n        (rst_n),
		.fifo_write   (fifo_write),
		.fifo_data_in (fifo_data_in),
		.port         (u_pack_if.packer)
	);

	bulk_store u_bulk_store (
		.ti_clk (ti_clk),
		.rst_n  (rst_n),
		.port   (u_store_if.store)
	);

	word_unpacker u_word_unpacker (
		.ti_clk        (ti_clk),
		.rst_n         (rst_n),
		.port          (u_store_if.unpacker),
		.rd_chunk      (u_store_if.rd_chunk),
		.fifo_read     (fifo_read),
		.fifo_data_out (fifo_data_out)
	);

	////////////////////////////////////////////////////////////
	// Control and monitoring
	////////////////////////////////////////////////////////////

	transfer_ctrl u_transfer_ctrl (
		.ti_clk (ti_clk),
		.rst_n  (rst_n),
		.pack   (u_pack_if.ctrl),
		.store  (u_store_if.ctrl)
	);

	occupancy_monitor u_occupancy_monitor (
		.ti_clk       (ti_clk),
		.rst_n        (rst_n),
		.pack_level   (u_pack_if.word_level),
		.store_level  (u_store_if.chunk_level),
		.unpack_level (u_store_if.word_level),
		.num_words    (num_words)
	);

endmodule

// ==== sim/tb_model.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Longest wait in clock cycles
localparam int WAIT_LIMIT = 4000;
// Fifteen chunks fill the unpacker as far as the controller refills it
localparam int UNPACK_FILL = 60;
localparam int WPC = deep_fifo_pkg::WORDS_PER_CHUNK;

logic [31:0]          lfsr_state = 32'h5d78;
deep_fifo_pkg::word_t model_q[$];
deep_fifo_pkg::word_t last_word = '0;
int                   write_total = 0;
int                   read_total = 0;
int                   error_count = 0;
int                   check_count = 0;

////////////////////////////////////////////////////////////
// Stimulus data
////////////////////////////////////////////////////////////

// Fibonacci LFSR with taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
	return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
endfunction

function automatic deep_fifo_pkg::word_t next_random_word();
	deep_fifo_pkg::word_t w;
	w = '0;
	for (int i = 0; i < deep_fifo_pkg::WORD_W; i++) begin
		lfsr_state = lfsr_step(lfsr_state);
		w = {w[deep_fifo_pkg::WORD_W-2:0], lfsr_state[0]};
	end
	return w;
endfunction

////////////////////////////////////////////////////////////
// Reference queue
////////////////////////////////////////////////////////////

function automatic void model_write(input deep_fifo_pkg::word_t w);
	model_q.push_back(w);
	write_total++;
endfunction

// Trailing words of a partial chunk never reach the output
function automatic int readable_words();
	return (write_total / WPC) * WPC - read_total;
endfunction

// Oldest readable word or the last one again when nothing is readable
function automatic deep_fifo_pkg::word_t expected_next_word();
	if (readable_words() > 0) begin
		last_word = model_q.pop_front();
		read_total++;
	end
	return last_word;
endfunction

function automatic int expected_count();
	return write_total - read_total;
endfunction

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
	check_count++;
	if (got !== exp) begin
		error_count++;
		$display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, got, exp);
	end
endtask

////////////////////////////////////////////////////////////
// Waits
////////////////////////////////////////////////////////////

// The count must reach the target before the limit runs out
task automatic wait_count(input int target);
	int cycles;
	cycles = 0;
	while (num_words !== 32'(target) && cycles < WAIT_LIMIT) begin
		@(posedge ti_clk);
		#2;
		cycles++;
	end
	if (num_words !== 32'(target)) begin
		$display("timeout: num_words never reached %0d", target);
	end
	check_value("num_words", num_words, 32'(target));
endtask

// Reads may start once the output buffer holds what it can
task automatic wait_unpacker_loaded();
	int target;
	int cycles;
	target = readable_words();
	if (target > UNPACK_FILL) begin
		target = UNPACK_FILL;
	end
	cycles = 0;
	while (int'(u_deep_fifo_top.u_word_unpacker.level) < target && cycles < WAIT_LIMIT) begin
		@(posedge ti_clk);
		#2;
		cycles++;
	end
	if (int'(u_deep_fifo_top.u_word_unpacker.level) < target) begin
		error_count++;
		$display("timeout: output buffer never filled up to %0d words", target);
	end
endtask

`endif

// ==== sim/tb_deep_fifo.sv ====
`timescale 1ns/1ps

module tb_deep_fifo;

	logic                  ti_clk = 1'b0;
	logic                  rst_n;
	logic                  fifo_write;
	deep_fifo_pkg::word_t  fifo_data_in;
	logic                  fifo_read;
	deep_fifo_pkg::word_t  fifo_data_out;
	deep_fifo_pkg::count_t num_words;

	// Read taken by the DUT on the last edge
	logic                 read_pending = 1'b0;
	deep_fifo_pkg::word_t read_expected;

	int test_count = 0;
	int test_fail_count = 0;
	int test_start_errors = 0;

	deep_fifo_top u_deep_fifo_top (
		.ti_clk        (ti_clk),
		.rst_n         (rst_n),
		.fifo_write    (fifo_write),
		.fifo_data_in  (fifo_data_in),
		.fifo_read     (fifo_read),
		.fifo_data_out (fifo_data_out),
		.num_words     (num_words)
	);

	`include "tb_model.svh"

	always #20 ti_clk = ~ti_clk;

	////////////////////////////////////////////////////////////
	// Compare process
	////////////////////////////////////////////////////////////

	always @(posedge ti_clk) begin
		read_pending <= rst_n && fifo_read;
	end

	// Output settled half a cycle after the capturing edge
	always @(negedge ti_clk) begin
		if (read_pending) begin
			read_expected = expected_next_word();
			check_value("fifo_data_out", 32'(fifo_data_out), 32'(read_expected));
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	task automatic drive_cycle(input bit wr, input bit rd);
		deep_fifo_pkg::word_t w;
		w = fifo_data_in;
		if (wr) begin
			w = next_random_word();
			model_write(w);
		end
		fifo_data_in = w;
		fifo_write   = wr;
		fifo_read    = rd;
		@(posedge ti_clk);
		#2;
	endtask

	task automatic idle_cycles(input int n);
		fifo_write = 1'b0;
		fifo_read  = 1'b0;
		repeat (n) begin
			@(posedge ti_clk);
			#2;
		end
	endtask

	task automatic write_burst(input int n);
		repeat (n) drive_cycle(1'b1, 1'b0);
		idle_cycles(1);
	endtask

	task automatic read_burst(input int n);
		repeat (n) drive_cycle(1'b0, 1'b1);
		idle_cycles(1);
	endtask

	task automatic drain_readable();
		int n;
		n = readable_words();
		wait_unpacker_loaded();
		read_burst(n);
	endtask

	task automatic end_test(input string name);
		int errs;
		errs = error_count - test_start_errors;
		test_count++;
		if (errs == 0) begin
			$display("test %0s: passed", name);
		end else begin
			test_fail_count++;
			$display("test %0s: failed with %0d errors", name, errs);
		end
		test_start_errors = error_count;
	endtask

	initial begin
		rst_n        = 1'b0;
		fifo_write   = 1'b0;
		fifo_data_in = '0;
		fifo_read    = 1'b0;
		repeat (8) @(posedge ti_clk);
		#2;
		rst_n = 1'b1;
		idle_cycles(2);

		check_value("num_words", num_words, 32'd0);
		check_value("fifo_data_out", 32'(fifo_data_out), 32'd0);
		end_test("reset_state");

		write_burst(400);
		wait_count(400);
		drain_readable();
		end_test("stream_and_drain");

		// Preload, then write every cycle and read every other one
		write_burst(160);
		wait_unpacker_loaded();
		for (int i = 0; i < 120; i++) begin
			drive_cycle(1'b1, (i % 2) == 0);
		end
		idle_cycles(1);
		wait_count(expected_count());
		drain_readable();
		end_test("count_after_settling");

		write_burst(6);
		wait_count(6);
		wait_unpacker_loaded();
		read_burst(5);
		end_test("residual_words");

		read_burst(3);
		wait_count(2);
		end_test("underflow_repeat");

		// Two residual words are still held from before
		write_burst(1000);
		wait_count(expected_count());
		drain_readable();
		wait_count(2);
		end_test("deep_occupancy");

		$display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
			test_count, test_fail_count, check_count, error_count);
		if (error_count == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+sim
verilog/deep_fifo_pkg.sv
verilog/chunk_if.sv
verilog/word_packer.sv
verilog/word_unpacker.sv
verilog/bulk_store.sv
verilog/transfer_ctrl.sv
verilog/occupancy_monitor.sv
verilog/deep_fifo_top.sv
sim/tb_deep_fifo.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal -j 0 --top-module tb_deep_fifo -f build.f &&
./obj_dir/Vtb_deep_fifo | tee /dev/stderr | grep -q "^TEST PASS$" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
